// ==== src/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	// Memory depths, 6-bit word index each
	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 64;

	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_J     = 6'h02;

	// R-type funct codes, all-zero word is sll $0 and acts as the nop
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;
	localparam logic [5:0] FN_SLL = 6'h00;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_SLL
	} alu_op_t;

	typedef enum logic [1:0] {
		FWD_REG = 2'd0,
		FWD_EX  = 2'd1,
		FWD_MEM = 2'd2,
		FWD_WB  = 2'd3
	} fwd_sel_t;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} i_fmt_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [25:0] target26;
	} j_fmt_t;

	// One instruction word, three layouts
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} instr_t;

	typedef struct packed {
		logic    regwrite;
		logic    memtoreg;
		logic    memread;
		logic    memwrite;
		logic    isbranch;
		logic    isjump;
		logic    regdst;
		logic    alusrc;
		alu_op_t alu_op;
	} ctrl_t;

	typedef struct packed {
		logic [31:0] pc_next;
		instr_t      instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t       ctrl;
		logic [31:0] pc_next;
		logic [31:0] data_s;
		logic [31:0] data_t;
		logic [31:0] imm;
		logic [31:0] pc_jump;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [4:0]  shamt;
	} id_ex_t;

	typedef struct packed {
		ctrl_t       ctrl;
		logic [31:0] pc_branch;
		logic        zero;
		logic [31:0] alures;
		logic [31:0] data_t;
		logic [4:0]  wreg;
	} ex_mem_t;

	typedef struct packed {
		logic        regwrite;
		logic [31:0] wdata;
		logic [4:0]  wreg;
	} mem_wb_t;

	// Retire strobe
	typedef struct packed {
		logic        valid;
		logic [4:0]  wreg;
		logic [31:0] wdata;
	} wb_event_t;

	// Store strobe, addr is a word address
	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
		logic [31:0] data;
	} store_event_t;

endpackage

`default_nettype wire

// ==== src/decode_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_ctrl (
	input  wire mips_pkg::instr_t instr,
	output mips_pkg::ctrl_t       ctrl
);
	import mips_pkg::*;

	always_comb begin
		ctrl = '0;
		case (instr.r.op)
			OP_RTYPE: begin
				ctrl.regwrite = 1'b1;
				ctrl.regdst = 1'b1;
				case (instr.r.funct)
					FN_ADD: ctrl.alu_op = ALU_ADD;
					FN_SUB: ctrl.alu_op = ALU_SUB;
					FN_AND: ctrl.alu_op = ALU_AND;
					FN_OR:  ctrl.alu_op = ALU_OR;
					FN_SLT: ctrl.alu_op = ALU_SLT;
					FN_SLL: ctrl.alu_op = ALU_SLL;
					// Unsupported funct behaves as a nop
					default: ctrl = '0;
				endcase
			end
			OP_ADDI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc = 1'b1;
				ctrl.alu_op = ALU_ADD;
			end
			OP_LW: begin
				ctrl.regwrite = 1'b1;
				ctrl.memtoreg = 1'b1;
				ctrl.memread = 1'b1;
				ctrl.alusrc = 1'b1;
				ctrl.alu_op = ALU_ADD;
			end
			OP_SW: begin
				ctrl.memwrite = 1'b1;
				ctrl.alusrc = 1'b1;
				ctrl.alu_op = ALU_ADD;
			end
			// Equality test through the zero flag
			OP_BEQ: begin
				ctrl.isbranch = 1'b1;
				ctrl.alu_op = ALU_SUB;
			end
			OP_J: begin
				ctrl.isjump = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/fwd_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fwd_unit (
	input  wire [4:0]          rs,
	input  wire [4:0]          rt,
	input  wire [4:0]          ex_dst,
	input  wire [4:0]          mem_dst,
	input  wire [4:0]          wb_dst,
	input  wire                ex_rw,
	input  wire                mem_rw,
	input  wire                wb_rw,
	output mips_pkg::fwd_sel_t sel_s,
	output mips_pkg::fwd_sel_t sel_t
);
	import mips_pkg::*;

	// Youngest producer wins
	function automatic fwd_sel_t source_of(input logic [4:0] src);
		if (src == 5'd0)
			return FWD_REG;
		if (ex_rw && src == ex_dst)
			return FWD_EX;
		if (mem_rw && src == mem_dst)
			return FWD_MEM;
		if (wb_rw && src == wb_dst)
			return FWD_WB;
		return FWD_REG;
	endfunction

	always_comb begin
		sel_s = source_of(rs);
		sel_t = source_of(rt);
	end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input  wire        clk,
	input  wire        rst_n,
	input  wire [4:0]  raddr_s,
	input  wire [4:0]  raddr_t,
	input  wire        we,
	input  wire [4:0]  waddr,
	input  wire [31:0] wdata,
	output logic [31:0] rdata_s,
	output logic [31:0] rdata_t
);
	logic [31:0] regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			regs <= '{default: '0};
		else if (we && waddr != 5'd0)
			regs[waddr] <= wdata;
	end

	// $0 reads zero, same-cycle write is bypassed to the read
	assign rdata_s = (raddr_s == 5'd0) ? 32'd0 :
		(we && waddr == raddr_s) ? wdata : regs[raddr_s];
	assign rdata_t = (raddr_t == 5'd0) ? 32'd0 :
		(we && waddr == raddr_t) ? wdata : regs[raddr_t];

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  wire mips_pkg::alu_op_t op,
	input  wire [31:0]             a,
	input  wire [31:0]             b,
	input  wire [4:0]              shamt,
	output logic [31:0]            result,
	output logic                   zero
);
	import mips_pkg::*;

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			// Signed compare
			ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
			ALU_SLL: result = b << shamt;
			default: result = '0;
		endcase
	end

	assign zero = (result == 32'd0);

endmodule

`default_nettype wire

// ==== src/word_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module word_mem #(
	parameter int WORDS = mips_pkg::IMEM_WORDS
) (
	input  wire                       clk,
	input  wire                       we,
	input  wire [$clog2(WORDS)-1:0]   addr,
	input  wire [31:0]                wdata,
	output logic [31:0]               rdata
);
	logic [31:0] mem [WORDS];

	// Write on the edge
	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
	end

	// Read is combinational
	assign rdata = mem[addr];

endmodule

`default_nettype wire

// ==== src/cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    halt,
	input  wire                    prog_we,
	input  wire [5:0]              prog_addr,
	input  wire [31:0]             prog_data,
	output mips_pkg::wb_event_t    wb_event,
	output mips_pkg::store_event_t store_event
);
	import mips_pkg::*;

	logic [31:0] pc;
	logic [31:0] pc_in;
	logic [31:0] if_pc_next;
	instr_t      if_instr;
	if_id_t      if_id;
	id_ex_t      id_ex, id_ex_d;
	ex_mem_t     ex_mem, ex_mem_d;
	mem_wb_t     mem_wb, mem_wb_d;
	ctrl_t       id_ctrl;
	fwd_sel_t    sel_s, sel_t;
	logic [31:0] rf_s, rf_t;
	logic [31:0] alu_b, ex_alures, dmem_rdata, mem_wdata;
	logic [4:0]  ex_wreg;
	logic        ex_zero, ex_fwd_ok, take_branch, take_jump, flush_id;

	//////////////////////////////
	// Fetch
	//////////////////////////////

	assign if_pc_next = pc + 32'd4;
	assign take_branch = ex_mem.ctrl.isbranch & ex_mem.zero;
	assign take_jump = id_ex.ctrl.isjump;
	assign flush_id = take_branch | take_jump;

	// Branch in MEM is older than a jump in EX
	assign pc_in = take_branch ? ex_mem.pc_branch :
		take_jump ? id_ex.pc_jump : if_pc_next;

	// Program load shares the single address port
	word_mem #(.WORDS(IMEM_WORDS)) imem (
		.clk(clk),
		.we(prog_we),
		.addr(prog_we ? prog_addr : pc[7:2]),
		.wdata(prog_data),
		.rdata(if_instr)
	);

	//////////////////////////////
	// Decode
	//////////////////////////////

	decode_ctrl u_decode (
		.instr(if_id.instr),
		.ctrl(id_ctrl)
	);

	reg_file u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.raddr_s(if_id.instr.r.rs),
		.raddr_t(if_id.instr.r.rt),
		.we(mem_wb.regwrite & ~halt),
		.waddr(mem_wb.wreg),
		.wdata(mem_wb.wdata),
		.rdata_s(rf_s),
		.rdata_t(rf_t)
	);

	// A load's EX result is only its address
	assign ex_fwd_ok = id_ex.ctrl.regwrite & ~id_ex.ctrl.memread;

	fwd_unit u_fwd (
		.rs(if_id.instr.r.rs),
		.rt(if_id.instr.r.rt),
		.ex_dst(ex_wreg),
		.mem_dst(ex_mem.wreg),
		.wb_dst(mem_wb.wreg),
		.ex_rw(ex_fwd_ok),
		.mem_rw(ex_mem.ctrl.regwrite),
		.wb_rw(mem_wb.regwrite),
		.sel_s(sel_s),
		.sel_t(sel_t)
	);

	function automatic logic [31:0] operand(input fwd_sel_t sel, input logic [31:0] rf_val);
		case (sel)
			FWD_EX:  return ex_alures;
			FWD_MEM: return mem_wdata;
			FWD_WB:  return mem_wb.wdata;
			default: return rf_val;
		endcase
	endfunction

	always_comb begin
		id_ex_d.ctrl = id_ctrl;
		id_ex_d.pc_next = if_id.pc_next;
		id_ex_d.data_s = operand(sel_s, rf_s);
		id_ex_d.data_t = operand(sel_t, rf_t);
		id_ex_d.imm = {{16{if_id.instr.i.imm16[15]}}, if_id.instr.i.imm16};
		id_ex_d.pc_jump = {if_id.pc_next[31:28], if_id.instr.j.target26, 2'b00};
		id_ex_d.rt = if_id.instr.r.rt;
		id_ex_d.rd = if_id.instr.r.rd;
		id_ex_d.shamt = if_id.instr.r.shamt;
	end

	//////////////////////////////
	// Execute
	//////////////////////////////

	assign alu_b = id_ex.ctrl.alusrc ? id_ex.imm : id_ex.data_t;
	assign ex_wreg = id_ex.ctrl.regdst ? id_ex.rd : id_ex.rt;

	alu u_alu (
		.op(id_ex.ctrl.alu_op),
		.a(id_ex.data_s),
		.b(alu_b),
		.shamt(id_ex.shamt),
		.result(ex_alures),
		.zero(ex_zero)
	);

	always_comb begin
		ex_mem_d.ctrl = id_ex.ctrl;
		ex_mem_d.pc_branch = id_ex.pc_next + {id_ex.imm[29:0], 2'b00};
		ex_mem_d.zero = ex_zero;
		ex_mem_d.alures = ex_alures;
		ex_mem_d.data_t = id_ex.data_t;
		ex_mem_d.wreg = ex_wreg;
	end

	//////////////////////////////
	// Memory and write-back
	//////////////////////////////

	word_mem #(.WORDS(DMEM_WORDS)) dmem (
		.clk(clk),
		.we(ex_mem.ctrl.memwrite & ~halt),
		.addr(ex_mem.alures[7:2]),
		.wdata(ex_mem.data_t),
		.rdata(dmem_rdata)
	);

	assign mem_wdata = ex_mem.ctrl.memtoreg ? dmem_rdata : ex_mem.alures;

	always_comb begin
		mem_wb_d.regwrite = ex_mem.ctrl.regwrite;
		mem_wb_d.wdata = mem_wdata;
		mem_wb_d.wreg = ex_mem.wreg;
	end

	// PC and stage registers, frozen by halt
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
			if_id <= '0;
			id_ex <= '0;
			ex_mem <= '0;
			mem_wb <= '0;
		end else if (!halt) begin
			pc <= pc_in;
			if_id <= flush_id ? '0 : {if_pc_next, if_instr};
			id_ex <= flush_id ? '0 : id_ex_d;
			ex_mem <= take_branch ? '0 : ex_mem_d;
			mem_wb <= mem_wb_d;
		end
	end

	// Strobes; writes to $0 (including nops) are not reported
	assign wb_event.valid = mem_wb.regwrite & (mem_wb.wreg != 5'd0) & ~halt;
	assign wb_event.wreg = mem_wb.wreg;
	assign wb_event.wdata = mem_wb.wdata;

	assign store_event.valid = ex_mem.ctrl.memwrite & ~halt;
	assign store_event.addr = {2'b00, ex_mem.alures[31:2]};
	assign store_event.data = ex_mem.data_t;

endmodule

`default_nettype wire

// ==== bench/cpu_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_chk (
	input wire                         clk,
	input wire                         rst_n,
	input wire                         halt,
	input wire mips_pkg::wb_event_t    wb_event,
	input wire mips_pkg::store_event_t store_event
);
	int unsigned fail_count = 0;

	// Strobes stay low in reset
	quiet_in_reset: assert property (@(posedge clk)
		!rst_n |-> !wb_event.valid && !store_event.valid)
		else begin
			fail_count++;
			$error("strobe valid while reset is asserted");
		end

	quiet_in_halt: assert property (@(posedge clk) disable iff (!rst_n)
		halt |-> !wb_event.valid)
		else begin
			fail_count++;
			$error("write-back strobe valid while halted");
		end

	no_store_in_halt: assert property (@(posedge clk)
		store_event.valid |-> !halt)
		else begin
			fail_count++;
			$error("store strobe valid while halted");
		end

	// $0 writes are never reported
	no_wb_to_zero: assert property (@(posedge clk) disable iff (!rst_n)
		wb_event.valid |-> wb_event.wreg != 5'd0)
		else begin
			fail_count++;
			$error("write-back strobe names register 0");
		end

	known_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
		wb_event.valid |-> !$isunknown(wb_event.wdata))
		else begin
			fail_count++;
			$error("write-back data has unknown bits");
		end

endmodule

bind cpu cpu_chk chk (
	.clk(clk),
	.rst_n(rst_n),
	.halt(halt),
	.wb_event(wb_event),
	.store_event(store_event)
);

`default_nettype wire

// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;
	import mips_pkg::*;

	localparam int PROG_WORDS = 60;
	localparam int CYCLE_LIMIT = 16 + 60 + 4 * 60 + 50;
	localparam int DRAIN_CYCLES = 16;

	logic         clk = 1'b0;
	logic         rst_n;
	logic         halt;
	logic         prog_we;
	logic [5:0]   prog_addr;
	logic [31:0]  prog_data;
	wb_event_t    wb_event;
	store_event_t store_event;

	logic [31:0] prog [PROG_WORDS];
	logic [36:0] exp_wb [$];
	logic [63:0] exp_st [$];
	logic [31:0] rng_state = 32'h466864dc;
	int unsigned cycles = 0;
	int          errors = 0;
	logic        timed_out;

	cpu UUT (
		.clk(clk),
		.rst_n(rst_n),
		.halt(halt),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.wb_event(wb_event),
		.store_event(store_event)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
		cycles <= cycles + 1;

	//////////////////////////////
	// Program generation
	//////////////////////////////

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic logic [31:0] enc_r(input logic [5:0] fn, input int rs, input int rt,
		input int rd, input int sh);
		return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input int rs, input int rt,
		input int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] enc_j(input int target);
		return {OP_J, target[25:0]};
	endfunction

	task automatic build_program();
		logic [31:0] r;
		int kind;
		int dst;
		int rs;
		int rt;
		int last_dst;
		int prev_dst;
		last_dst = 1;
		prev_dst = 2;
		// Seed $1..$8 with some negative values
		for (int k = 1; k <= 8; k++)
			prog[k - 1] = enc_i(OP_ADDI, 0, k, k * 1234 - 5000);
		// Sources lean on the last two results
		for (int k = 8; k < 32; k++) begin
			r = next_rand();
			kind = r[31:16] % 7;
			dst = r[27:24] % 9;
			rs = r[28] ? last_dst : r[23:20] % 9;
			rt = r[29] ? prev_dst : r[19:16] % 9;
			case (kind)
				0: prog[k] = enc_r(FN_ADD, rs, rt, dst, 0);
				1: prog[k] = enc_r(FN_SUB, rs, rt, dst, 0);
				2: prog[k] = enc_r(FN_AND, rs, rt, dst, 0);
				3: prog[k] = enc_r(FN_OR, rs, rt, dst, 0);
				4: prog[k] = enc_r(FN_SLT, rs, rt, dst, 0);
				5: prog[k] = enc_r(FN_SLL, 0, rt, dst, r[12:8]);
				default: prog[k] = enc_i(OP_ADDI, rs, dst, r[15:0]);
			endcase
			prev_dst = last_dst;
			last_dst = dst;
		end
		// Two stores and two loads with one filler each
		prog[32] = enc_i(OP_SW, 0, 3, 8);
		prog[33] = enc_i(OP_SW, 0, 5, 12);
		prog[34] = enc_i(OP_LW, 0, 9, 8);
		prog[35] = enc_i(OP_ADDI, 0, 10, 7);
		prog[36] = enc_r(FN_ADD, 9, 10, 11, 0);
		prog[37] = enc_i(OP_LW, 0, 12, 12);
		prog[38] = enc_i(OP_ADDI, 0, 13, 5);
		// Not-taken beq then a taken one over 42..44
		prog[39] = enc_i(OP_BEQ, 13, 10, 2);
		prog[40] = enc_i(OP_ADDI, 12, 14, 1);
		prog[41] = enc_i(OP_BEQ, 14, 14, 3);
		prog[42] = enc_i(OP_ADDI, 0, 15, 1);
		prog[43] = enc_i(OP_ADDI, 0, 16, 2);
		prog[44] = enc_i(OP_ADDI, 0, 17, 3);
		prog[45] = enc_i(OP_ADDI, 14, 18, 100);
		prog[46] = enc_j(49);
		prog[47] = enc_i(OP_ADDI, 0, 19, 9);
		prog[48] = enc_i(OP_ADDI, 0, 20, 9);
		prog[49] = enc_i(OP_SW, 0, 18, 16);
		prog[50] = enc_r(FN_OR, 18, 11, 21, 0);
		prog[51] = enc_j(51);
		// Retires only if fetch runs past the loop
		for (int k = 52; k < PROG_WORDS; k++)
			prog[k] = enc_i(OP_ADDI, 0, 25, k);
	endtask

	//////////////////////////////
	// ISA reference model
	//////////////////////////////

	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] dmem [64];
		logic [31:0] w;
		logic [31:0] imm;
		logic [31:0] val;
		logic [31:0] a;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  dst;
		int          pc;
		int          next_pc;
		int          steps;
		logic        wr;
		logic        done;
		for (int k = 0; k < 32; k++)
			regs[k] = '0;
		pc = 0;
		steps = 0;
		done = 1'b0;
		while (!done && steps < 4 * PROG_WORDS) begin
			w = prog[pc];
			rs = w[25:21];
			rt = w[20:16];
			imm = {{16{w[15]}}, w[15:0]};
			a = regs[rs] + imm;
			next_pc = pc + 1;
			wr = 1'b0;
			dst = rt;
			val = '0;
			case (w[31:26])
				OP_RTYPE: begin
					wr = 1'b1;
					dst = w[15:11];
					case (w[5:0])
						FN_ADD: val = regs[rs] + regs[rt];
						FN_SUB: val = regs[rs] - regs[rt];
						FN_AND: val = regs[rs] & regs[rt];
						FN_OR:  val = regs[rs] | regs[rt];
						FN_SLT: val = {31'd0, $signed(regs[rs]) < $signed(regs[rt])};
						FN_SLL: val = regs[rt] << w[10:6];
						default: wr = 1'b0;
					endcase
				end
				OP_ADDI: begin
					wr = 1'b1;
					val = a;
				end
				OP_LW: begin
					wr = 1'b1;
					val = dmem[a[7:2]];
				end
				OP_SW: begin
					dmem[a[7:2]] = regs[rt];
					exp_st.push_back({a >> 2, regs[rt]});
				end
				OP_BEQ: begin
					if (regs[rs] == regs[rt])
						next_pc = pc + 1 + int'($signed(imm));
				end
				OP_J: begin
					next_pc = int'(w[25:0]);
					done = (next_pc == pc);
				end
				default: ;
			endcase
			if (wr && dst != 5'd0) begin
				regs[dst] = val;
				exp_wb.push_back({dst, val});
			end
			pc = next_pc;
			steps++;
		end
	endtask

	//////////////////////////////
	// Strobe checks
	//////////////////////////////

	always @(posedge clk) begin
		if (wb_event.valid) begin
			assert (exp_wb.size() > 0) else begin
				errors++;
				$display("error at %0t ns: unexpected write-back of $%0d = %h", $time,
					wb_event.wreg, wb_event.wdata);
			end
			if (exp_wb.size() > 0) begin
				assert ({wb_event.wreg, wb_event.wdata} == exp_wb[0]) else begin
					errors++;
					$display("error at %0t ns: write-back $%0d = %h, expected $%0d = %h",
						$time, wb_event.wreg, wb_event.wdata, exp_wb[0][36:32],
						exp_wb[0][31:0]);
				end
				void'(exp_wb.pop_front());
			end
		end
		if (store_event.valid) begin
			assert (exp_st.size() > 0) else begin
				errors++;
				$display("error at %0t ns: unexpected store of %h to word %0d", $time,
					store_event.data, store_event.addr);
			end
			if (exp_st.size() > 0) begin
				assert ({store_event.addr, store_event.data} == exp_st[0]) else begin
					errors++;
					$display("error at %0t ns: store %h to word %0d, expected %h to word %0d",
						$time, store_event.data, store_event.addr, exp_st[0][31:0],
						exp_st[0][63:32]);
				end
				void'(exp_st.pop_front());
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		halt = 1'b1;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		timed_out = 1'b0;
		build_program();
		run_model();
		// Load runs through and past reset
		for (int i = 0; i < PROG_WORDS; i++) begin
			@(posedge clk);
			if (i == 15)
				rst_n <= 1'b1;
			prog_we <= 1'b1;
			prog_addr <= 6'(i);
			prog_data <= prog[i];
		end
		@(posedge clk);
		prog_we <= 1'b0;
		@(posedge clk);
		halt <= 1'b0;
		while ((exp_wb.size() != 0 || exp_st.size() != 0) && cycles < CYCLE_LIMIT)
			@(negedge clk);
		if (cycles >= CYCLE_LIMIT) begin
			timed_out = 1'b1;
			$display("timeout: missing retirements, %0d write-backs and %0d stores never arrived",
				exp_wb.size(), exp_st.size());
		end else begin
			repeat (DRAIN_CYCLES) @(posedge clk);
		end
		$display("%0d strobe mismatches, %0d assertion failures in cpu_chk", errors,
			UUT.chk.fail_count);
		if (errors == 0 && UUT.chk.fail_count == 0 && !timed_out)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
src/mips_pkg.sv
src/decode_ctrl.sv
src/fwd_unit.sv
src/reg_file.sv
src/alu.sv
src/word_mem.sv
src/cpu.sv
bench/cpu_chk.sv
bench/cpu_tb.sv
